/* src/spi_flash_pkg.sv */
package spi_flash_pkg;

   localparam int FLASH_ADDR_W = 24;  // flash byte address
   localparam int WORD_W       = 32;
   localparam int SEG_LEN_W    = 6;   // bit count of one shift segment

   // operation requested through the CMD register
   typedef enum logic [1:0] {
      OP_NONE    = 2'd0,
      OP_WAKE    = 2'd1,
      OP_READ    = 2'd2,
      OP_PROGRAM = 2'd3
   } flash_op_e;

   // SPI NOR command bytes
   typedef enum logic [7:0] {
      FLASH_PP   = 8'h02,  // page program
      FLASH_READ = 8'h03,
      FLASH_WREN = 8'h06,  // write enable
      FLASH_WAKE = 8'hAB   // release from deep power-down
   } flash_opcode_e;

   // register byte offsets
   localparam logic [4:0] REG_ADDR   = 5'h00;
   localparam logic [4:0] REG_WDATA  = 5'h04;
   localparam logic [4:0] REG_RDATA  = 5'h08;
   localparam logic [4:0] REG_CMD    = 5'h0C;
   localparam logic [4:0] REG_STATUS = 5'h10;

   // AXI response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* src/spi_shift_if.sv */
`timescale 1ns/1ps

// one frame segment handed from the sequencer to the shift engine
interface spi_shift_if
   import spi_flash_pkg::*;
();

   logic                 start;    // one-cycle pulse
   logic [WORD_W-1:0]    tx_data;  // MSB aligned
   logic [SEG_LEN_W-1:0] nbits;
   logic                 keep_ss;  // chip select stays low into the next segment
   logic                 done;     // one-cycle pulse at segment end
   logic [WORD_W-1:0]    rx_data;  // received bits in the LSBs

   modport sequencer (
      output start, tx_data, nbits, keep_ss,
      input  done, rx_data
   );

   modport engine (
      input  start, tx_data, nbits, keep_ss,
      output done, rx_data
   );

endinterface

/* src/spi_shift_engine.sv */
`timescale 1ns/1ps

module spi_shift_engine
   import spi_flash_pkg::*;
#(
   parameter int clk_div = 4
) (
   input  logic        clk,
   input  logic        reset,
   spi_shift_if.engine shift,
   output logic        spi_sck,
   output logic        spi_ss_n,
   output logic        spi_mosi,
   input  logic        spi_miso
);

   localparam int DIV_W = $clog2(2 * clk_div);
   localparam int GAP_W = $clog2(clk_div + 1);

   typedef enum logic [1:0] {
      ENG_IDLE,
      ENG_GAP,    // chip select still serving its deselect time
      ENG_SHIFT
   } eng_state_e;

   eng_state_e           state;
   logic [DIV_W-1:0]     div_cnt;  // position inside one bit
   logic [GAP_W-1:0]     gap_cnt;
   logic [SEG_LEN_W-1:0] bit_cnt;
   logic [WORD_W-1:0]    shreg;
   logic                 miso_q;
   logic                 keep_q;
   logic                 sck_q;
   logic                 ss_n_q;
   logic                 done_q;
   logic                 rise_edge;
   logic                 fall_edge;

   assign rise_edge = (div_cnt == DIV_W'(clk_div - 1));      // end of low half
   assign fall_edge = (div_cnt == DIV_W'(2 * clk_div - 1));  // end of high half

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= ENG_IDLE;
         div_cnt <= '0;
         gap_cnt <= '0;
         bit_cnt <= '0;
         shreg   <= '0;
         sck_q   <= 1'b0;
         ss_n_q  <= 1'b1;
         done_q  <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (gap_cnt != '0)
            gap_cnt <= gap_cnt - 1'b1;
         case (state)
            ENG_IDLE: begin
               if (shift.start) begin
                  shreg   <= shift.tx_data;
                  bit_cnt <= shift.nbits;
                  div_cnt <= '0;
                  if (gap_cnt == '0) begin
                     ss_n_q <= 1'b0;
                     state  <= ENG_SHIFT;
                  end else begin
                     state <= ENG_GAP;
                  end
               end
            end
            ENG_GAP: begin
               if (gap_cnt == '0) begin
                  ss_n_q <= 1'b0;
                  state  <= ENG_SHIFT;
               end
            end
            ENG_SHIFT: begin
               div_cnt <= div_cnt + 1'b1;
               if (rise_edge)
                  sck_q <= 1'b1;
               if (fall_edge) begin
                  sck_q   <= 1'b0;
                  div_cnt <= '0;
                  shreg   <= {shreg[WORD_W-2:0], miso_q};  // next MOSI bit as SCK falls
                  bit_cnt <= bit_cnt - 1'b1;
                  if (bit_cnt == SEG_LEN_W'(1)) begin
                     done_q <= 1'b1;
                     state  <= ENG_IDLE;
                     if (!keep_q) begin
                        ss_n_q  <= 1'b1;
                        gap_cnt <= GAP_W'(clk_div);
                     end
                  end
               end
            end
            default: state <= ENG_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ENG_IDLE && shift.start)
         keep_q <= shift.keep_ss;
      if (state == ENG_SHIFT && rise_edge)
         miso_q <= spi_miso;  // sampled on the SCK rising edge
   end

   assign spi_sck       = sck_q;
   assign spi_ss_n      = ss_n_q;
   assign spi_mosi      = shreg[WORD_W-1];
   assign shift.done    = done_q;
   assign shift.rx_data = shreg;

endmodule

/* src/flash_cmd_sequencer.sv */
`timescale 1ns/1ps

module flash_cmd_sequencer
   import spi_flash_pkg::*;
#(
   parameter int wake_wait_cycles = 100
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    op_start,
   input  flash_op_e               op_code,
   input  logic [FLASH_ADDR_W-1:0] flash_addr,
   input  logic [WORD_W-1:0]       wr_word,
   output logic                    busy,
   output logic                    op_done,
   output logic [WORD_W-1:0]       rd_word,
   spi_shift_if.sequencer          shift
);

   localparam int WAIT_W = $clog2(wake_wait_cycles + 2);

   typedef enum logic [2:0] {
      IDLE,
      WAKE_CMD,   // wake frame, 8 bits
      WREN_CMD,   // write enable frame, 8 bits
      SETTLE,
      SEND_CMD,   // read or program opcode, frame stays open
      SEND_ADDR,
      XFER_DATA,
      FINISH
   } seq_state_e;

   seq_state_e              state;
   flash_op_e               op_q;
   logic [FLASH_ADDR_W-1:0] addr_q;
   logic [WORD_W-1:0]       wdata_q;
   logic [WAIT_W-1:0]       wait_cnt;
   logic                    start_q;
   logic [WORD_W-1:0]       seg_data;
   logic [SEG_LEN_W-1:0]    seg_bits;
   logic                    seg_keep;

   // opcode placed in the top byte so it leaves first
   function automatic logic [WORD_W-1:0] cmd_word(input flash_opcode_e code);
      return {code, {(WORD_W - 8){1'b0}}};
   endfunction

   // segment contents follow the current state
   always_comb begin
      seg_data = '0;
      seg_bits = '0;
      seg_keep = 1'b0;
      case (state)
         WAKE_CMD: begin
            seg_data = cmd_word(FLASH_WAKE);
            seg_bits = SEG_LEN_W'(8);
         end
         WREN_CMD: begin
            seg_data = cmd_word(FLASH_WREN);
            seg_bits = SEG_LEN_W'(8);
         end
         SEND_CMD: begin
            if (op_q == OP_PROGRAM)
               seg_data = cmd_word(FLASH_PP);
            else
               seg_data = cmd_word(FLASH_READ);
            seg_bits = SEG_LEN_W'(8);
            seg_keep = 1'b1;
         end
         SEND_ADDR: begin
            seg_data = {addr_q, {(WORD_W - FLASH_ADDR_W){1'b0}}};
            seg_bits = SEG_LEN_W'(FLASH_ADDR_W);
            seg_keep = 1'b1;
         end
         XFER_DATA: begin
            if (op_q == OP_PROGRAM)
               seg_data = wdata_q;  // reads shift out zeros
            seg_bits = SEG_LEN_W'(WORD_W);
         end
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= IDLE;
         op_q     <= OP_NONE;
         wait_cnt <= '0;
         start_q  <= 1'b0;
      end else begin
         start_q <= 1'b0;
         case (state)
            IDLE: begin
               if (op_start) begin
                  op_q    <= op_code;
                  start_q <= 1'b1;
                  case (op_code)
                     OP_WAKE:    state <= WAKE_CMD;
                     OP_READ:    state <= SEND_CMD;
                     OP_PROGRAM: state <= WREN_CMD;
                     default:    start_q <= 1'b0;
                  endcase
               end
            end
            WAKE_CMD, WREN_CMD: begin
               if (shift.done) begin
                  state    <= SETTLE;
                  wait_cnt <= WAIT_W'(wake_wait_cycles);
               end
            end
            SETTLE: begin
               if (wait_cnt > WAIT_W'(1)) begin
                  wait_cnt <= wait_cnt - 1'b1;
               end else if (op_q == OP_PROGRAM) begin
                  state   <= SEND_CMD;  // write enable latched, now the PP frame
                  start_q <= 1'b1;
               end else begin
                  state <= FINISH;
               end
            end
            SEND_CMD: begin
               if (shift.done) begin
                  state   <= SEND_ADDR;
                  start_q <= 1'b1;
               end
            end
            SEND_ADDR: begin
               if (shift.done) begin
                  state   <= XFER_DATA;
                  start_q <= 1'b1;
               end
            end
            XFER_DATA: if (shift.done) state <= FINISH;
            default:   state <= IDLE;  // FINISH
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == IDLE && op_start) begin
         addr_q  <= flash_addr;
         wdata_q <= wr_word;
      end
      if (state == XFER_DATA && shift.done && op_q == OP_READ)
         rd_word <= shift.rx_data;
   end

   assign busy          = (state != IDLE);
   assign op_done       = (state == FINISH);
   assign shift.start   = start_q;
   assign shift.tx_data = seg_data;
   assign shift.nbits   = seg_bits;
   assign shift.keep_ss = seg_keep;

endmodule

/* src/axil_flash_regs.sv */
`timescale 1ns/1ps

module axil_flash_regs
   import spi_flash_pkg::*;
(
   input  logic                    clk,
   input  logic                    reset,
   input  logic [4:0]              awaddr,
   input  logic                    awvalid,
   output logic                    awready,
   input  logic [31:0]             wdata,
   input  logic                    wvalid,
   output logic                    wready,
   output logic [1:0]              bresp,
   output logic                    bvalid,
   input  logic                    bready,
   input  logic [4:0]              araddr,
   input  logic                    arvalid,
   output logic                    arready,
   output logic [31:0]             rdata,
   output logic [1:0]              rresp,
   output logic                    rvalid,
   input  logic                    rready,
   input  logic                    busy,
   input  logic                    op_done,
   input  logic [WORD_W-1:0]       rd_word,
   output logic                    op_start,
   output flash_op_e               op_code,
   output logic [FLASH_ADDR_W-1:0] flash_addr,
   output logic [WORD_W-1:0]       wr_word
);

   logic [FLASH_ADDR_W-1:0] addr_q;
   logic [WORD_W-1:0]       wdata_q;
   logic [WORD_W-1:0]       rdata_q;
   logic                    done_q;   // sticky until the next CMD write
   logic                    status_busy;
   logic                    wr_fire;
   logic                    rd_fire;
   logic [1:0]              wr_resp;
   logic [1:0]              rd_resp;
   logic [31:0]             rd_mux;

   assign wr_fire     = awready && awvalid && wvalid;
   assign rd_fire     = arready && arvalid;
   assign status_busy = busy || op_start;  // covers the cycle before the sequencer leaves idle
   assign flash_addr  = addr_q;
   assign wr_word     = wdata_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         arready <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         // AW and W taken together, never while a B is pending
         awready <= awvalid && wvalid && !awready && !bvalid;
         wready  <= awvalid && wvalid && !awready && !bvalid;
         if (wr_fire)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
         arready <= arvalid && !arready && !rvalid;
         if (rd_fire)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         addr_q   <= '0;
         wdata_q  <= '0;
         rdata_q  <= '0;
         done_q   <= 1'b0;
         op_start <= 1'b0;
         op_code  <= OP_NONE;
      end else begin
         op_start <= 1'b0;
         if (op_done) begin
            done_q <= 1'b1;
            if (op_code == OP_READ)
               rdata_q <= rd_word;
         end
         if (wr_fire) begin
            case (awaddr)
               REG_ADDR:  addr_q  <= wdata[FLASH_ADDR_W-1:0];
               REG_WDATA: wdata_q <= wdata;
               REG_CMD: begin
                  if (!status_busy) begin
                     done_q   <= 1'b0;
                     op_code  <= flash_op_e'(wdata[1:0]);
                     op_start <= (wdata[1:0] != OP_NONE);
                  end
               end
               default: ;  // RDATA and STATUS are read only
            endcase
         end
      end
   end

   always_comb begin
      case (awaddr)
         REG_ADDR, REG_WDATA, REG_RDATA, REG_STATUS: wr_resp = RESP_OKAY;
         REG_CMD: wr_resp = status_busy ? RESP_SLVERR : RESP_OKAY;
         default: wr_resp = RESP_SLVERR;
      endcase
   end

   always_comb begin
      rd_resp = RESP_OKAY;
      case (araddr)
         REG_ADDR:   rd_mux = {{(32 - FLASH_ADDR_W){1'b0}}, addr_q};
         REG_WDATA:  rd_mux = wdata_q;
         REG_RDATA:  rd_mux = rdata_q;
         REG_CMD:    rd_mux = {30'd0, op_code};  // last operation issued
         REG_STATUS: rd_mux = {30'd0, done_q, status_busy};
         default: begin
            rd_mux  = '0;
            rd_resp = RESP_SLVERR;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (wr_fire)
         bresp <= wr_resp;
      if (rd_fire) begin
         rdata <= rd_mux;
         rresp <= rd_resp;
      end
   end

endmodule

/* src/spi_flash_ctrl.sv */
`timescale 1ns/1ps

module spi_flash_ctrl
   import spi_flash_pkg::*;
#(
   parameter int clk_div          = 4,
   parameter int wake_wait_cycles = 100
) (
   input  logic        clk,
   input  logic        reset,
   input  logic [4:0]  awaddr,
   input  logic        awvalid,
   output logic        awready,
   input  logic [31:0] wdata,
   input  logic        wvalid,
   output logic        wready,
   output logic [1:0]  bresp,
   output logic        bvalid,
   input  logic        bready,
   input  logic [4:0]  araddr,
   input  logic        arvalid,
   output logic        arready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   output logic        rvalid,
   input  logic        rready,
   output logic        spi_sck,
   output logic        spi_ss_n,
   output logic        spi_mosi,
   input  logic        spi_miso
);

   logic                    op_start;
   flash_op_e               op_code;
   logic [FLASH_ADDR_W-1:0] flash_addr;
   logic [WORD_W-1:0]       wr_word;
   logic                    busy;
   logic                    op_done;
   logic [WORD_W-1:0]       rd_word;

   spi_shift_if u_shift_if ();

   axil_flash_regs u_regs (
      .clk        (clk),
      .reset      (reset),
      .awaddr     (awaddr),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wvalid     (wvalid),
      .wready     (wready),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready),
      .busy       (busy),
      .op_done    (op_done),
      .rd_word    (rd_word),
      .op_start   (op_start),
      .op_code    (op_code),
      .flash_addr (flash_addr),
      .wr_word    (wr_word)
   );

   flash_cmd_sequencer #(
      .wake_wait_cycles (wake_wait_cycles)
   ) u_seq (
      .clk        (clk),
      .reset      (reset),
      .op_start   (op_start),
      .op_code    (op_code),
      .flash_addr (flash_addr),
      .wr_word    (wr_word),
      .busy       (busy),
      .op_done    (op_done),
      .rd_word    (rd_word),
      .shift      (u_shift_if.sequencer)
   );

   spi_shift_engine #(
      .clk_div (clk_div)
   ) u_engine (
      .clk      (clk),
      .reset    (reset),
      .shift    (u_shift_if.engine),
      .spi_sck  (spi_sck),
      .spi_ss_n (spi_ss_n),
      .spi_mosi (spi_mosi),
      .spi_miso (spi_miso)
   );

endmodule

/* sim/flash_model.sv */
`timescale 1ns/1ps

// behavioral SPI NOR flash, mode 0, 16 words of storage
module flash_model (
   input  logic sck,
   input  logic ss_n,
   input  logic mosi,
   output logic miso
);

   localparam logic [7:0] CMD_PP   = 8'h02;
   localparam logic [7:0] CMD_READ = 8'h03;
   localparam logic [7:0] CMD_WREN = 8'h06;
   localparam logic [7:0] CMD_WAKE = 8'hAB;

   logic [31:0] mem [16];
   logic [15:0] written;   // one flag per word
   logic [7:0]  opcode;
   logic [23:0] addr;
   logic [31:0] data_in;
   logic [31:0] data_out;
   logic        wel;       // write-enable latch
   logic        awake;     // starts in deep power-down
   int          bit_cnt;

   initial begin
      written = '0;
      wel     = 1'b0;
      awake   = 1'b0;
      miso    = 1'b0;
      bit_cnt = 0;
   end

   always @(negedge ss_n)
      bit_cnt = 0;

   always @(posedge sck) begin
      if (!ss_n) begin
         if (bit_cnt < 8)
            opcode = {opcode[6:0], mosi};
         else if (bit_cnt < 32)
            addr = {addr[22:0], mosi};
         else
            data_in = {data_in[30:0], mosi};
         bit_cnt = bit_cnt + 1;
         if (bit_cnt == 32 && opcode == CMD_READ) begin
            if (written[addr[5:2]])
               data_out = mem[addr[5:2]];
            else
               data_out = {8'h00, addr} ^ 32'hA5A5_0000;  // fill pattern
         end
      end
   end

   // read data leaves MSB first, changing as SCK falls
   always @(negedge sck) begin
      if (!ss_n && awake && opcode == CMD_READ && bit_cnt >= 32 && bit_cnt < 64) begin
         miso     = data_out[31];
         data_out = {data_out[30:0], 1'b0};
      end
   end

   // commands take effect when chip select rises
   always @(posedge ss_n) begin
      if (bit_cnt == 8 && opcode == CMD_WAKE) begin
         awake = 1'b1;
      end else if (awake && bit_cnt == 8 && opcode == CMD_WREN) begin
         wel = 1'b1;
      end else if (awake && wel && bit_cnt == 64 && opcode == CMD_PP) begin
         mem[addr[5:2]]     = data_in;
         written[addr[5:2]] = 1'b1;
         wel                = 1'b0;  // one program per write enable
      end
   end

endmodule

/* sim/spi_flash_ctrl_assert.sv */
`timescale 1ns/1ps

module spi_flash_ctrl_assert (
   input logic clk,
   input logic reset,
   input logic sck,
   input logic ss_n,
   input logic mosi,
   input logic done
);

   // mode 0 idles low, no clock pulses while deselected
   sck_idle_low: assert property (@(posedge clk) disable iff (reset)
      ss_n |-> !sck)
      else $error("SCK high while chip select is inactive");

   done_one_cycle: assert property (@(posedge clk) disable iff (reset)
      done |=> !done)
      else $error("shift done held longer than one cycle");

   mosi_stable: assert property (@(posedge clk) disable iff (reset)
      (sck && $past(sck)) |-> $stable(mosi))
      else $error("MOSI changed while SCK was high");

endmodule

bind spi_shift_engine spi_flash_ctrl_assert u_assert (
   .clk   (clk),
   .reset (reset),
   .sck   (spi_sck),
   .ss_n  (spi_ss_n),
   .mosi  (spi_mosi),
   .done  (done_q)
);

/* sim/tb_spi_flash_ctrl.sv */
`timescale 1ns/1ps

module tb_spi_flash_ctrl
   import spi_flash_pkg::*;
();

   localparam int CLK_DIV     = 2;
   localparam int WAKE_WAIT   = 20;
   localparam int NUM_ENTRIES = 10;
   localparam int WATCHDOG_CYCLES =
      (NUM_ENTRIES + 1) * (64 * 2 * CLK_DIV + 2 * WAKE_WAIT + 200);

   typedef struct packed {
      flash_op_e   op;
      logic [23:0] addr;
      logic [31:0] wdata;
      logic        collide;    // second CMD write while busy
      logic [31:0] exp_rdata;  // RDATA after the operation
      logic [1:0]  exp_bresp;  // response to the CMD write
   } entry_t;

   logic        clk;
   logic        reset;
   logic [4:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [4:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;
   logic        spi_sck;
   logic        spi_ss_n;
   logic        spi_mosi;
   logic        spi_miso;

   entry_t      tbl [NUM_ENTRIES];
   int          n_entries;
   logic [15:0] lfsr_state;
   logic [31:0] shadow_mem [16];  // what the flash model should hold
   logic [15:0] shadow_written;
   logic [31:0] last_rdata;
   int          value_errs;
   int          other_errs;

   spi_flash_ctrl #(
      .clk_div          (CLK_DIV),
      .wake_wait_cycles (WAKE_WAIT)
   ) u_dut (
      .clk (clk), .reset (reset),
      .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
      .wdata (wdata), .wvalid (wvalid), .wready (wready),
      .bresp (bresp), .bvalid (bvalid), .bready (bready),
      .araddr (araddr), .arvalid (arvalid), .arready (arready),
      .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
      .spi_sck (spi_sck), .spi_ss_n (spi_ss_n),
      .spi_mosi (spi_mosi), .spi_miso (spi_miso)
   );

   flash_model u_flash (
      .sck  (spi_sck),
      .ss_n (spi_ss_n),
      .mosi (spi_mosi),
      .miso (spi_miso)
   );

   always #20 clk = ~clk;

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] next_lfsr(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] random_word();
      logic [31:0] w;
      w = '0;
      for (int b = 0; b < 32; b++) begin
         lfsr_state = next_lfsr(lfsr_state);  // one step per bit
         w = {w[30:0], lfsr_state[0]};
      end
      return w;
   endfunction

   task automatic add_entry(input flash_op_e op, input logic [23:0] addr, input logic collide);
      entry_t e;
      e.op        = op;
      e.addr      = addr;
      e.wdata     = random_word();
      e.collide   = collide;
      e.exp_bresp = RESP_OKAY;
      if (op == OP_PROGRAM) begin
         shadow_mem[addr[5:2]]     = e.wdata;
         shadow_written[addr[5:2]] = 1'b1;
      end else if (op == OP_READ) begin
         if (shadow_written[addr[5:2]])
            last_rdata = shadow_mem[addr[5:2]];
         else
            last_rdata = {8'h00, addr} ^ 32'hA5A5_0000;
      end
      e.exp_rdata    = last_rdata;  // wake and program leave RDATA alone
      tbl[n_entries] = e;
      n_entries      = n_entries + 1;
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
      value_errs = value_errs + 1;
   endtask

   task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
      @(negedge clk);
      awaddr  = addr;
      wdata   = data;
      awvalid = 1'b1;
      wvalid  = 1'b1;
      do @(negedge clk); while (!awready);
      if (!wready) begin
         $display("write channel was not ready together with the address channel at %0t",
                  $time);
         other_errs = other_errs + 1;
      end
      @(negedge clk);  // accepted on the edge just passed
      awvalid = 1'b0;
      wvalid  = 1'b0;
      while (!bvalid) @(negedge clk);
      resp   = bresp;
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
      @(negedge clk);
      araddr  = addr;
      arvalid = 1'b1;
      do @(negedge clk); while (!arready);
      @(negedge clk);
      arvalid = 1'b0;
      while (!rvalid) @(negedge clk);
      data   = rdata;
      resp   = rresp;
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
   endtask

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("timeout: the operations did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Something failed");
      $finish;
   end

   initial begin : main
      logic [31:0] data;
      logic [1:0]  resp;
      entry_t      e;
      clk = 1'b0;
      reset = 1'b1;
      awaddr = '0;
      awvalid = 1'b0;
      wdata = '0;
      wvalid = 1'b0;
      bready = 1'b0;
      araddr = '0;
      arvalid = 1'b0;
      rready = 1'b0;
      value_errs = 0;
      other_errs = 0;
      n_entries = 0;
      lfsr_state = 16'd39;
      shadow_written = '0;
      last_rdata = '0;

      add_entry(OP_WAKE,    24'h000000, 1'b0);  // model starts powered down
      add_entry(OP_READ,    24'h000010, 1'b0);  // never written
      add_entry(OP_PROGRAM, 24'h000024, 1'b1);
      add_entry(OP_READ,    24'h000024, 1'b0);
      add_entry(OP_PROGRAM, 24'h000024, 1'b0);  // needs a fresh WREN
      add_entry(OP_READ,    24'h000024, 1'b0);
      add_entry(OP_WAKE,    24'h000000, 1'b0);
      add_entry(OP_READ,    24'h123458, 1'b0);
      add_entry(OP_PROGRAM, 24'h00003C, 1'b0);
      add_entry(OP_READ,    24'h00003C, 1'b0);

      repeat (3) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      axi_read(REG_STATUS, data, resp);
      if (data !== 32'h0) report_mismatch("status", data, 32'h0);
      axi_read(REG_RDATA, data, resp);
      if (data !== 32'h0) report_mismatch("rdata", data, 32'h0);

      for (int i = 0; i < n_entries; i++) begin
         e = tbl[i];
         axi_write(REG_ADDR, {8'h00, e.addr}, resp);
         if (resp !== RESP_OKAY) report_mismatch("bresp", resp, RESP_OKAY);
         axi_write(REG_WDATA, e.wdata, resp);
         if (resp !== RESP_OKAY) report_mismatch("bresp", resp, RESP_OKAY);
         axi_read(REG_ADDR, data, resp);
         if (data !== {8'h00, e.addr}) report_mismatch("addr", data, {8'h00, e.addr});
         axi_read(REG_WDATA, data, resp);
         if (data !== e.wdata) report_mismatch("wdata", data, e.wdata);

         axi_write(REG_CMD, {30'd0, e.op}, resp);
         if (resp !== e.exp_bresp) report_mismatch("bresp", resp, e.exp_bresp);
         if (e.collide) begin
            axi_write(REG_CMD, {30'd0, OP_READ}, resp);  // must bounce off
            if (resp !== RESP_SLVERR) report_mismatch("bresp", resp, RESP_SLVERR);
         end

         do axi_read(REG_STATUS, data, resp); while (data[1] !== 1'b1);
         if (data !== 32'h2) report_mismatch("status", data, 32'h2);
         axi_read(REG_RDATA, data, resp);
         if (data !== e.exp_rdata) report_mismatch("rdata", data, e.exp_rdata);
      end

      axi_write(5'h14, 32'h1, resp);  // nothing mapped here
      if (resp !== RESP_SLVERR) report_mismatch("bresp", resp, RESP_SLVERR);
      axi_read(5'h1C, data, resp);
      if (resp !== RESP_SLVERR) report_mismatch("rresp", resp, RESP_SLVERR);

      $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

/* compile.f */
src/spi_flash_pkg.sv
src/spi_shift_if.sv
src/spi_shift_engine.sv
src/flash_cmd_sequencer.sv
src/axil_flash_regs.sv
src/spi_flash_ctrl.sv
sim/flash_model.sv
sim/spi_flash_ctrl_assert.sv
sim/tb_spi_flash_ctrl.sv

/* Bender.yml */
package:
  name: spi_flash_ctrl

sources:
  # RTL in compile order
  - src/spi_flash_pkg.sv
  - src/spi_shift_if.sv
  - src/spi_shift_engine.sv
  - src/flash_cmd_sequencer.sv
  - src/axil_flash_regs.sv
  - src/spi_flash_ctrl.sv

  # flash model, bound assertions and testbench
  - target: simulation
    files:
      - sim/flash_model.sv
      - sim/spi_flash_ctrl_assert.sv
      - sim/tb_spi_flash_ctrl.sv
